/* files.f */
verilog/id_pkg.sv
verilog/id_fwd_if.sv
verilog/id_inst_latch.sv
verilog/id_decoder.sv
verilog/id_regfile.sv
verilog/id_operand_read.sv
verilog/id_stage.sv
verification/id_stage_assertions.sv
verification/tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_id_stage -f files.f -o sim_id_stage &&
./obj_dir/sim_id_stage +verilator+error+limit+100000 | tee /dev/stderr | grep -qx "sim passed" &&
echo "run ok" ||
{ echo "run FAILED"; exit 1; }

/* verification/id_stage_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage_assertions #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            stall_i,
    input wire logic            flush_i,
    input wire logic [XLEN-1:0] if_pc_i,
    input id_pkg::inst_t        if_inst_i,
    input wire logic            ex_we_i,
    input id_pkg::reg_addr_t    ex_waddr_i,
    input wire logic [XLEN-1:0] ex_wdata_i,
    input wire logic            mem_we_i,
    input id_pkg::reg_addr_t    mem_waddr_i,
    input wire logic [XLEN-1:0] mem_wdata_i,
    input wire logic            wb_we_i,
    input id_pkg::reg_addr_t    wb_waddr_i,
    input wire logic [XLEN-1:0] wb_wdata_i,
    input wire logic            ex_load_i,
    input id_pkg::reg_addr_t    ex_rd_i,
    input wire logic            valid_o,
    input wire logic [XLEN-1:0] pc_o,
    input id_pkg::inst_t        inst_o,
    input id_pkg::reg_addr_t    rd_o,
    input wire logic [XLEN-1:0] rs1_data_o,
    input wire logic [XLEN-1:0] rs2_data_o,
    input id_pkg::alu_op_e      alu_op_o,
    input id_pkg::src1_sel_e    src1_sel_o,
    input id_pkg::src2_sel_e    src2_sel_o,
    input wire logic            word_op_o,
    input wire logic            rf_we_o,
    input wire logic            mem_read_o,
    input wire logic            mem_write_o,
    input id_pkg::mem_size_e    mem_size_o,
    input wire logic            mem_unsigned_o,
    input id_pkg::branch_op_e   branch_op_o,
    input wire logic            stallreq_o
);
    import id_pkg::*;

    int              errors = 0;
    logic [XLEN-1:0] shadow [32];
    logic [XLEN-1:0] exp_rs1;
    logic [XLEN-1:0] exp_rs2;
    logic [17:0]     exp_dec;
    logic [17:0]     got_dec;
    logic            exp_stall;
    reg_addr_t       rs1;
    reg_addr_t       rs2;

    // spec funct3 meaning, alt selects sub or sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // packed as alu, src1, src2, word, rf_we, mem_read, mem_write, unsigned, branch
    function automatic logic [17:0] expect_decode(input inst_t inst);
        alu_op_e    alu;
        src1_sel_e  s1;
        src2_sel_e  s2;
        logic       word;
        logic       we;
        logic       rd;
        logic       wr;
        logic       uns;
        branch_op_e br;
        logic [2:0] f3;
        alu  = ALU_NOP;
        s1   = SRC1_RS1;
        s2   = SRC2_RS2;
        word = 1'b0;
        we   = 1'b0;
        rd   = 1'b0;
        wr   = 1'b0;
        uns  = 1'b0;
        br   = BR_NONE;
        f3   = inst[14:12];
        casez ({inst[31:25], f3, inst[6:0]})
            {7'b???????, 3'b???, OPC_LUI}: begin
                s1 = SRC1_ZERO;
                s2 = SRC2_IMM_U;
                we = 1'b1;
            end
            {7'b???????, 3'b???, OPC_AUIPC}: begin
                alu = ALU_ADD;
                s1  = SRC1_PC;
                s2  = SRC2_IMM_U;
                we  = 1'b1;
            end
            {7'b???????, 3'b000, OPC_OP_IMM}, {7'b???????, 3'b01?, OPC_OP_IMM},
            {7'b???????, 3'b100, OPC_OP_IMM}, {7'b???????, 3'b11?, OPC_OP_IMM}: begin
                alu = arith_op(f3, 1'b0);
                s2  = SRC2_IMM_I;
                we  = 1'b1;
            end
            {7'b000000?, 3'b001, OPC_OP_IMM}, {7'b0?0000?, 3'b101, OPC_OP_IMM}: begin
                alu = arith_op(f3, inst[30]);
                s2  = SRC2_SHAMT;
                we  = 1'b1;
            end
            {7'b???????, 3'b000, OPC_OP_IMM_32}: begin
                alu  = ALU_ADD;
                s2   = SRC2_IMM_I;
                word = 1'b1;
                we   = 1'b1;
            end
            {7'b0000000, 3'b001, OPC_OP_IMM_32}, {7'b0?00000, 3'b101, OPC_OP_IMM_32}: begin
                alu  = arith_op(f3, inst[30]);
                s2   = SRC2_SHAMT;
                word = 1'b1;
                we   = 1'b1;
            end
            {7'b0000000, 3'b???, OPC_OP}, {7'b0100000, 3'b000, OPC_OP},
            {7'b0100000, 3'b101, OPC_OP}: begin
                alu = arith_op(f3, inst[30]);
                we  = 1'b1;
            end
            {7'b0?00000, 3'b000, OPC_OP_32}, {7'b0000000, 3'b001, OPC_OP_32},
            {7'b0?00000, 3'b101, OPC_OP_32}: begin
                alu  = arith_op(f3, inst[30]);
                word = 1'b1;
                we   = 1'b1;
            end
            {7'b???????, 3'b0??, OPC_LOAD}, {7'b???????, 3'b10?, OPC_LOAD},
            {7'b???????, 3'b110, OPC_LOAD}: begin
                alu = ALU_ADD;
                s2  = SRC2_IMM_I;
                we  = 1'b1;
                rd  = 1'b1;
                uns = f3[2];
            end
            {7'b???????, 3'b0??, OPC_STORE}: begin
                alu = ALU_ADD;
                s2  = SRC2_IMM_S;
                wr  = 1'b1;
            end
            {7'b???????, 3'b???, OPC_JAL}, {7'b???????, 3'b000, OPC_JALR}: begin
                alu = ALU_ADD;
                s1  = SRC1_PC;
                s2  = SRC2_FOUR;
                we  = 1'b1;
                br  = inst[3] ? BR_JAL : BR_JALR;
            end
            {7'b???????, 3'b00?, OPC_BRANCH}, {7'b???????, 3'b1??, OPC_BRANCH}: begin
                case (f3)
                    3'b000:  br = BR_BEQ;
                    3'b001:  br = BR_BNE;
                    3'b100:  br = BR_BLT;
                    3'b101:  br = BR_BGE;
                    3'b110:  br = BR_BLTU;
                    default: br = BR_BGEU;
                endcase
            end
            default: ;
        endcase
        return {alu, s1, s2, word, we, rd, wr, uns, br};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_we_i && wb_waddr_i != '0) begin
            shadow[wb_waddr_i] <= wb_wdata_i;
        end
    end

    assign rs1 = inst_o[19:15];
    assign rs2 = inst_o[24:20];

    // ex beats mem beats wb, then the shadow copy
    always_comb begin
        if (rs1 == '0) exp_rs1 = '0;
        else if (ex_we_i && ex_waddr_i == rs1) exp_rs1 = ex_wdata_i;
        else if (mem_we_i && mem_waddr_i == rs1) exp_rs1 = mem_wdata_i;
        else if (wb_we_i && wb_waddr_i == rs1) exp_rs1 = wb_wdata_i;
        else exp_rs1 = shadow[rs1];
        if (rs2 == '0) exp_rs2 = '0;
        else if (ex_we_i && ex_waddr_i == rs2) exp_rs2 = ex_wdata_i;
        else if (mem_we_i && mem_waddr_i == rs2) exp_rs2 = mem_wdata_i;
        else if (wb_we_i && wb_waddr_i == rs2) exp_rs2 = wb_wdata_i;
        else exp_rs2 = shadow[rs2];
    end

    assign exp_dec   = expect_decode(inst_o);
    assign got_dec   = {alu_op_o, src1_sel_o, src2_sel_o, word_op_o, rf_we_o,
                        mem_read_o, mem_write_o, mem_unsigned_o, branch_op_o};
    assign exp_stall = valid_o && ex_load_i && ex_rd_i != '0 && (ex_rd_i == rs1 || ex_rd_i == rs2);

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !(valid_o || rf_we_o || mem_read_o || mem_write_o || stallreq_o))
        else begin
            errors++;
            $error("control outputs active during or right after reset");
        end

    flush_bubble: assert property (@(posedge clk) disable iff (rst) flush_i |=> !valid_o)
        else begin
            errors++;
            $error("Mismatch valid_o got %h expected 0 after flush", $sampled(valid_o));
        end

    stall_bubble: assert property (@(posedge clk) disable iff (rst) stall_i |-> !valid_o)
        else begin
            errors++;
            $error("Mismatch valid_o got %h expected 0 while stalled", $sampled(valid_o));
        end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall_i && !flush_i |=> $stable(pc_o) && $stable(inst_o))
        else begin
            errors++;
            $error("Mismatch pc_o/inst_o got %h/%h expected %h/%h", $sampled(pc_o),
                   $sampled(inst_o), $past(pc_o), $past(inst_o));
        end

    pc_load: assert property (@(posedge clk) disable iff (rst)
        !stall_i && !flush_i |=> pc_o == $past(if_pc_i))
        else begin
            errors++;
            $error("Mismatch pc_o got %h expected %h", $sampled(pc_o), $past(if_pc_i));
        end

    // rd field sits in bits 11:7 of the fetched word
    inst_load: assert property (@(posedge clk) disable iff (rst)
        !stall_i && !flush_i |=> inst_o == $past(if_inst_i) && rd_o == $past(if_inst_i[11:7]))
        else begin
            errors++;
            $error("Mismatch inst_o/rd_o got %h/%h expected %h/%h", $sampled(inst_o),
                   $sampled(rd_o), $past(if_inst_i), $past(if_inst_i[11:7]));
        end

    decode_fields: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> got_dec == exp_dec)
        else begin
            errors++;
            $error("Mismatch decode fields got %h expected %h for inst %h",
                   $sampled(got_dec), $sampled(exp_dec), $sampled(inst_o));
        end

    decode_size: assert property (@(posedge clk) disable iff (rst)
        valid_o && (exp_dec[6] || exp_dec[5]) |-> mem_size_o == inst_o[13:12])
        else begin
            errors++;
            $error("Mismatch mem_size_o got %h expected %h", $sampled(mem_size_o),
                   $sampled(inst_o[13:12]));
        end

    rs1_value: assert property (@(posedge clk) disable iff (rst) rs1_data_o == exp_rs1)
        else begin
            errors++;
            $error("Mismatch rs1_data_o got %h expected %h", $sampled(rs1_data_o),
                   $sampled(exp_rs1));
        end

    rs2_value: assert property (@(posedge clk) disable iff (rst) rs2_data_o == exp_rs2)
        else begin
            errors++;
            $error("Mismatch rs2_data_o got %h expected %h", $sampled(rs2_data_o),
                   $sampled(exp_rs2));
        end

    load_use: assert property (@(posedge clk) disable iff (rst) stallreq_o == exp_stall)
        else begin
            errors++;
            $error("Mismatch stallreq_o got %h expected %h", $sampled(stallreq_o),
                   $sampled(exp_stall));
        end

endmodule

bind id_stage id_stage_assertions #(.XLEN(XLEN)) checks_i (.*);

`default_nettype wire

/* verification/tb_id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int XLEN           = 64;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
    localparam int NUM_INST       = 50;

    logic            clk;
    logic            rst;
    logic            stall_i;
    logic            flush_i;
    logic            if_valid_i;
    logic [XLEN-1:0] if_pc_i;
    inst_t           if_inst_i;
    logic            ex_we_i;
    reg_addr_t       ex_waddr_i;
    logic [XLEN-1:0] ex_wdata_i;
    logic            mem_we_i;
    reg_addr_t       mem_waddr_i;
    logic [XLEN-1:0] mem_wdata_i;
    logic            wb_we_i;
    reg_addr_t       wb_waddr_i;
    logic [XLEN-1:0] wb_wdata_i;
    logic            ex_load_i;
    reg_addr_t       ex_rd_i;
    logic            valid_o;
    logic [XLEN-1:0] pc_o;
    inst_t           inst_o;
    reg_addr_t       rd_o;
    logic [XLEN-1:0] rs1_data_o;
    logic [XLEN-1:0] rs2_data_o;
    alu_op_e         alu_op_o;
    src1_sel_e       src1_sel_o;
    src2_sel_e       src2_sel_o;
    logic            word_op_o;
    logic            rf_we_o;
    logic            mem_read_o;
    logic            mem_write_o;
    mem_size_e       mem_size_o;
    logic            mem_unsigned_o;
    branch_op_e      branch_op_o;
    logic            stallreq_o;

    logic [31:0] lcg_state = 32'h568d;
    int          cycles = 0;
    int          errors;

    // RV64I encodings with register fields zero, last one is unknown
    inst_t inst_table [NUM_INST] = '{
        32'h00000037, 32'h00000017, 32'h00000013, 32'h00002013, 32'h00003013,
        32'h00004013, 32'h00006013, 32'h00007013, 32'h00001013, 32'h00005013,
        32'h40005013, 32'h0000001b, 32'h0000101b, 32'h0000501b, 32'h4000501b,
        32'h00000033, 32'h40000033, 32'h00001033, 32'h00002033, 32'h00003033,
        32'h00004033, 32'h00005033, 32'h40005033, 32'h00006033, 32'h00007033,
        32'h0000003b, 32'h4000003b, 32'h0000103b, 32'h0000503b, 32'h4000503b,
        32'h00000003, 32'h00001003, 32'h00002003, 32'h00003003, 32'h00004003,
        32'h00005003, 32'h00006003, 32'h00000023, 32'h00001023, 32'h00002023,
        32'h00003023, 32'h0000006f, 32'h00000067, 32'h00000063, 32'h00001063,
        32'h00004063, 32'h00005063, 32'h00006063, 32'h00007063, 32'h0000007f
    };

    id_stage #(.XLEN(XLEN)) id_stage_i (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // registers x0..x7 only, so forwarding hits are frequent
    function automatic inst_t pick_inst();
        logic [31:0] r;
        inst_t       inst;
        r    = next_rand();
        inst = inst_table[r[31:16] % NUM_INST];
        inst[11:7]  = {2'b00, r[2:0]};
        inst[19:15] = {2'b00, r[5:3]};
        inst[24:20] = {2'b00, r[8:6]};
        return inst;
    endfunction

    // one cycle of random fetch, forwarding and hazard inputs
    task automatic drive_random();
        logic [31:0] r;
        r = next_rand();
        stall_i     <= (r[2:0] == 3'd0);
        flush_i     <= (r[5:3] == 3'd0);
        if_valid_i  <= r[6] | r[7];
        if_pc_i     <= {next_rand(), next_rand()};
        if_inst_i   <= pick_inst();
        ex_we_i     <= r[8];
        ex_waddr_i  <= {2'b00, r[11:9]};
        ex_wdata_i  <= {next_rand(), next_rand()};
        mem_we_i    <= r[12];
        mem_waddr_i <= {2'b00, r[15:13]};
        mem_wdata_i <= {next_rand(), next_rand()};
        wb_we_i     <= r[16] | r[17];
        wb_waddr_i  <= {2'b00, r[20:18]};
        wb_wdata_i  <= {next_rand(), next_rand()};
        ex_load_i   <= r[21];
        ex_rd_i     <= {2'b00, r[24:22]};
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        if_valid_i  = 1'b0;
        if_pc_i     = '0;
        if_inst_i   = '0;
        ex_we_i     = 1'b0;
        ex_waddr_i  = '0;
        ex_wdata_i  = '0;
        mem_we_i    = 1'b0;
        mem_waddr_i = '0;
        mem_wdata_i = '0;
        wb_we_i     = 1'b0;
        wb_waddr_i  = '0;
        wb_wdata_i  = '0;
        ex_load_i   = 1'b0;
        ex_rd_i     = '0;
        // fetch and forwarding stay busy while reset is held
        repeat (5) begin
            @(posedge clk);
            drive_random();
        end
        rst <= 1'b0;
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            drive_random();
        end
        repeat (2) @(posedge clk);
        errors = tb_id_stage.id_stage_i.checks_i.errors;
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/id_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module id_decoder (
    input  id_pkg::inst_t       inst_i,
    input  wire logic           valid_i,
    output id_pkg::reg_addr_t   rd_o,
    output id_pkg::alu_op_e     alu_op_o,
    output id_pkg::src1_sel_e   src1_sel_o,
    output id_pkg::src2_sel_e   src2_sel_o,
    output logic                word_op_o,
    output logic                rf_we_o,
    output logic                mem_read_o,
    output logic                mem_write_o,
    output id_pkg::mem_size_e   mem_size_o,
    output logic                mem_unsigned_o,
    output id_pkg::branch_op_e  branch_op_o
);
    import id_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       rf_we;
    logic       mem_read;
    logic       mem_write;
    alu_op_e    op_alu;
    alu_op_e    op_shr;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];

    // funct3 to alu op for the arithmetic groups, bit 30 picks sra
    always_comb begin
        op_shr = inst_i[30] ? ALU_SRA : ALU_SRL;
        case (funct3)
            3'b000:  op_alu = ALU_ADD;
            3'b001:  op_alu = ALU_SLL;
            3'b010:  op_alu = ALU_SLT;
            3'b011:  op_alu = ALU_SLTU;
            3'b100:  op_alu = ALU_XOR;
            3'b101:  op_alu = op_shr;
            3'b110:  op_alu = ALU_OR;
            default: op_alu = ALU_AND;
        endcase
    end

    always_comb begin
        legal          = 1'b0;
        alu_op_o       = ALU_NOP;
        src1_sel_o     = SRC1_RS1;
        src2_sel_o     = SRC2_RS2;
        word_op_o      = 1'b0;
        rf_we          = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_size_o     = mem_size_e'(funct3[1:0]);
        mem_unsigned_o = 1'b0;
        branch_op_o    = BR_NONE;
        case (opcode)
            OPC_LUI: begin
                legal      = 1'b1;
                src1_sel_o = SRC1_ZERO;
                src2_sel_o = SRC2_IMM_U;
                rf_we      = 1'b1;
            end
            OPC_AUIPC: begin
                legal      = 1'b1;
                alu_op_o   = ALU_ADD;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_IMM_U;
                rf_we      = 1'b1;
            end
            OPC_OP_IMM: begin
                // slli needs bit 30 clear
                legal      = !(funct3 == 3'b001 && inst_i[30]);
                alu_op_o   = op_alu;
                src2_sel_o = (funct3[1:0] == 2'b01) ? SRC2_SHAMT : SRC2_IMM_I;
                rf_we      = 1'b1;
            end
            OPC_OP_IMM_32: begin
                legal      = (funct3 == 3'b000) || (funct3 == 3'b001 && !inst_i[30])
                             || funct3 == 3'b101;
                alu_op_o   = op_alu;
                src2_sel_o = (funct3 == 3'b000) ? SRC2_IMM_I : SRC2_SHAMT;
                word_op_o  = 1'b1;
                rf_we      = 1'b1;
            end
            OPC_OP, OPC_OP_32: begin
                // only add/sub and srl/sra take funct7 0100000
                if (funct7 == 7'b0000000) begin
                    legal = (opcode == OPC_OP) || funct3 inside {3'b000, 3'b001, 3'b101};
                end else if (funct7 == 7'b0100000) begin
                    legal = (funct3 == 3'b000) || (funct3 == 3'b101);
                end
                alu_op_o  = (funct3 == 3'b000 && inst_i[30]) ? ALU_SUB : op_alu;
                word_op_o = (opcode == OPC_OP_32);
                rf_we     = 1'b1;
            end
            OPC_LOAD: begin
                legal          = (funct3 != 3'b111);
                alu_op_o       = ALU_ADD;
                src2_sel_o     = SRC2_IMM_I;
                rf_we          = 1'b1;
                mem_read       = 1'b1;
                mem_unsigned_o = funct3[2];
            end
            OPC_STORE: begin
                legal      = !funct3[2];
                alu_op_o   = ALU_ADD;
                src2_sel_o = SRC2_IMM_S;
                mem_write  = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                legal       = (opcode == OPC_JAL) || (funct3 == 3'b000);
                alu_op_o    = ALU_ADD;
                src1_sel_o  = SRC1_PC;
                src2_sel_o  = SRC2_FOUR;
                rf_we       = 1'b1;
                branch_op_o = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
            end
            OPC_BRANCH: begin
                legal = (funct3 != 3'b010) && (funct3 != 3'b011);
                case (funct3)
                    3'b000:  branch_op_o = BR_BEQ;
                    3'b001:  branch_op_o = BR_BNE;
                    3'b100:  branch_op_o = BR_BLT;
                    3'b101:  branch_op_o = BR_BGE;
                    3'b110:  branch_op_o = BR_BLTU;
                    default: branch_op_o = BR_BGEU;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // unknown encodings fall back to a bubble
        if (!legal) begin
            alu_op_o       = ALU_NOP;
            src1_sel_o     = SRC1_RS1;
            src2_sel_o     = SRC2_RS2;
            word_op_o      = 1'b0;
            mem_size_o     = MEM_B;
            mem_unsigned_o = 1'b0;
            branch_op_o    = BR_NONE;
        end
    end

    assign rf_we_o     = rf_we & legal & valid_i;
    assign mem_read_o  = mem_read & legal & valid_i;
    assign mem_write_o = mem_write & legal & valid_i;

endmodule

`default_nettype wire

/* verilog/id_fwd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface id_fwd_if #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
);
    import id_pkg::*;

    logic            ex_we;
    reg_addr_t       ex_waddr;
    logic [XLEN-1:0] ex_wdata;
    logic            mem_we;
    reg_addr_t       mem_waddr;
    logic [XLEN-1:0] mem_wdata;
    logic            wb_we;
    reg_addr_t       wb_waddr;
    logic [XLEN-1:0] wb_wdata;

    modport src (
        output ex_we, ex_waddr, ex_wdata,
        output mem_we, mem_waddr, mem_wdata,
        output wb_we, wb_waddr, wb_wdata
    );

    modport sink (
        input ex_we, ex_waddr, ex_wdata,
        input mem_we, mem_waddr, mem_wdata,
        input wb_we, wb_waddr, wb_wdata
    );

endinterface

`default_nettype wire

/* verilog/id_inst_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module id_inst_latch #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          stall_i,
    input  wire logic          flush_i,
    input  wire logic          if_valid_i,
    input  wire logic [XLEN-1:0] if_pc_i,
    input  id_pkg::inst_t      if_inst_i,
    output logic               valid_o,
    output logic [XLEN-1:0]    pc_o,
    output id_pkg::inst_t      inst_o
);

    logic valid_q;

    // flush wins over stall
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
            pc_o    <= '0;
            inst_o  <= '0;
        end else if (!stall_i) begin
            valid_q <= if_valid_i;
            pc_o    <= if_pc_i;
            inst_o  <= if_inst_i;
        end
    end

    // bubble while held
    assign valid_o = valid_q & ~stall_i;

endmodule

`default_nettype wire

/* verilog/id_operand_read.sv */
`timescale 1ns/100ps
`default_nettype none

module id_operand_read #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  id_pkg::inst_t      inst_i,
    input  wire logic          valid_i,
    id_fwd_if.sink             fwd,
    input  wire logic          ex_load_i,
    input  id_pkg::reg_addr_t  ex_rd_i,
    output logic [XLEN-1:0]    rs1_data_o,
    output logic [XLEN-1:0]    rs2_data_o,
    output logic               stallreq_o
);
    import id_pkg::*;

    reg_addr_t       rs [2];
    logic [XLEN-1:0] rf_data [2];
    logic [XLEN-1:0] op_data [2];

    assign rs[0] = inst_i[19:15];
    assign rs[1] = inst_i[24:20];

    id_regfile #(.XLEN(XLEN)) regfile_i (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (rs[0]),
        .raddr2_i (rs[1]),
        .we_i     (fwd.wb_we),
        .waddr_i  (fwd.wb_waddr),
        .wdata_i  (fwd.wb_wdata),
        .rdata1_o (rf_data[0]),
        .rdata2_o (rf_data[1])
    );

    // youngest producer first, x0 never forwards
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (rs[i] != '0 && fwd.ex_we && fwd.ex_waddr == rs[i]) begin
                op_data[i] = fwd.ex_wdata;
            end else if (rs[i] != '0 && fwd.mem_we && fwd.mem_waddr == rs[i]) begin
                op_data[i] = fwd.mem_wdata;
            end else if (rs[i] != '0 && fwd.wb_we && fwd.wb_waddr == rs[i]) begin
                op_data[i] = fwd.wb_wdata;
            end else begin
                op_data[i] = rf_data[i];
            end
        end
    end

    assign rs1_data_o = op_data[0];
    assign rs2_data_o = op_data[1];

    // load result not ready until mem
    assign stallreq_o = valid_i && ex_load_i && ex_rd_i != '0
                        && (ex_rd_i == rs[0] || ex_rd_i == rs[1]);

endmodule

`default_nettype wire

/* verilog/id_pkg.sv */
`default_nettype none

package id_pkg;

    parameter int XLEN_DEFAULT = 64;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes of the base integer set
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_RS2, SRC2_IMM_I, SRC2_IMM_U, SRC2_SHAMT, SRC2_FOUR, SRC2_IMM_S
    } src2_sel_e;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W, MEM_D} mem_size_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_op_e;

endpackage

`default_nettype wire

/* verilog/id_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module id_regfile #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  id_pkg::reg_addr_t  raddr1_i,
    input  id_pkg::reg_addr_t  raddr2_i,
    input  wire logic          we_i,
    input  id_pkg::reg_addr_t  waddr_i,
    input  wire logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0]    rdata1_o,
    output logic [XLEN-1:0]    rdata2_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage #(
    parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            stall_i,
    input  wire logic            flush_i,
    input  wire logic            if_valid_i,
    input  wire logic [XLEN-1:0] if_pc_i,
    input  id_pkg::inst_t        if_inst_i,
    input  wire logic            ex_we_i,
    input  id_pkg::reg_addr_t    ex_waddr_i,
    input  wire logic [XLEN-1:0] ex_wdata_i,
    input  wire logic            mem_we_i,
    input  id_pkg::reg_addr_t    mem_waddr_i,
    input  wire logic [XLEN-1:0] mem_wdata_i,
    input  wire logic            wb_we_i,
    input  id_pkg::reg_addr_t    wb_waddr_i,
    input  wire logic [XLEN-1:0] wb_wdata_i,
    input  wire logic            ex_load_i,
    input  id_pkg::reg_addr_t    ex_rd_i,
    output logic                 valid_o,
    output logic [XLEN-1:0]      pc_o,
    output id_pkg::inst_t        inst_o,
    output id_pkg::reg_addr_t    rd_o,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    output id_pkg::alu_op_e      alu_op_o,
    output id_pkg::src1_sel_e    src1_sel_o,
    output id_pkg::src2_sel_e    src2_sel_o,
    output logic                 word_op_o,
    output logic                 rf_we_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output id_pkg::mem_size_e    mem_size_o,
    output logic                 mem_unsigned_o,
    output id_pkg::branch_op_e   branch_op_o,
    output logic                 stallreq_o
);

    id_fwd_if #(.XLEN(XLEN)) fwd_if ();

    assign fwd_if.ex_we     = ex_we_i;
    assign fwd_if.ex_waddr  = ex_waddr_i;
    assign fwd_if.ex_wdata  = ex_wdata_i;
    assign fwd_if.mem_we    = mem_we_i;
    assign fwd_if.mem_waddr = mem_waddr_i;
    assign fwd_if.mem_wdata = mem_wdata_i;
    assign fwd_if.wb_we     = wb_we_i;
    assign fwd_if.wb_waddr  = wb_waddr_i;
    assign fwd_if.wb_wdata  = wb_wdata_i;

    id_inst_latch #(.XLEN(XLEN)) inst_latch_i (
        .clk        (clk),
        .rst        (rst),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .if_valid_i (if_valid_i),
        .if_pc_i    (if_pc_i),
        .if_inst_i  (if_inst_i),
        .valid_o    (valid_o),
        .pc_o       (pc_o),
        .inst_o     (inst_o)
    );

    id_decoder decoder_i (
        .inst_i         (inst_o),
        .valid_i        (valid_o),
        .rd_o           (rd_o),
        .alu_op_o       (alu_op_o),
        .src1_sel_o     (src1_sel_o),
        .src2_sel_o     (src2_sel_o),
        .word_op_o      (word_op_o),
        .rf_we_o        (rf_we_o),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .mem_size_o     (mem_size_o),
        .mem_unsigned_o (mem_unsigned_o),
        .branch_op_o    (branch_op_o)
    );

    id_operand_read #(.XLEN(XLEN)) operand_read_i (
        .clk        (clk),
        .rst        (rst),
        .inst_i     (inst_o),
        .valid_i    (valid_o),
        .fwd        (fwd_if.sink),
        .ex_load_i  (ex_load_i),
        .ex_rd_i    (ex_rd_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o),
        .stallreq_o (stallreq_o)
    );

endmodule

`default_nettype wire
